// ==== ramTestTop.f ====
src/ramTestPkg.sv
src/quadRamSequencer.sv
src/captureBuffer.sv
src/readbackChecker.sv
src/ramTestTop.sv
dv/tbClock.sv
dv/quadRamModel.sv
dv/ramTestTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.
# A $fatal in the testbench gives a nonzero exit status, so set -e ends the script on failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f ramTestTop.f \
	--top-module ramTestTb \
	-o ramTestSim

./obj_dir/ramTestSim

// ==== dv/ramTestTrace.txt ====
// Columns are op, fault, err, count, probeA, wordA, probeB, wordB, all in hex
// Op 1 reads and op 0 writes, and a fault of 400 means none
1 400 1 3FF 000 0000 123 0000
0 400 0 000 000 0000 3FF 0000
1 400 0 000 000 0000 3FF 03FF
1 155 1 001 155 FEAA 2AA 02AA
1 400 0 000 155 0155 001 0001
0 3FF 0 000 155 0155 3FF 03FF
1 3FF 1 001 3FF FC00 000 0000

// ==== dv/ramTestTb.sv ====
`timescale 1ns/1ns

module ramTestTb;
	import ramTestPkg::*;

	localparam int DONE_LIMIT = 5000;  // A read takes about 2100 cycles
	localparam int CS_LIMIT   = 16;

	logic          iCLK;
	logic          porRst;
	logic          scnRst;  // Reset applied before each scenario
	logic          testEn;
	logic          rwSel;
	bufAddrT       memRa;
	dqWordT        memRd;
	logic          busy;
	logic          testDone;
	logic          testErr;
	mismatchCountT mismatchCount;
	dqWordT        ramIn;
	ramBusT        ramOut;
	logic          faultEn;
	bufAddrT       faultAddr;
	dqWordT        firstCmd;
	dqWordT        secondCmd;

	tbClock u_clk
	(
		.iCLK   (iCLK),
		.porRst (porRst)
	);

	ramTestTop u_dut
	(
		.iCLK          (iCLK),
		.iRST          (porRst | scnRst),
		.testEn        (testEn),
		.rwSel         (rwSel),
		.memRa         (memRa),
		.memRd         (memRd),
		.busy          (busy),
		.testDone      (testDone),
		.testErr       (testErr),
		.mismatchCount (mismatchCount),
		.ramIn         (ramIn),
		.ramOut        (ramOut)
	);

	quadRamModel u_ram
	(
		.iCLK      (iCLK),
		.ramBus    (ramOut),
		.faultEn   (faultEn),
		.faultAddr (faultAddr),
		.ramIn     (ramIn),
		.firstCmd  (firstCmd),
		.secondCmd (secondCmd)
	);

	// Drive and sample point, 2 ns after the rising edge
	task automatic tick();
		@(posedge iCLK);
		#2;
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input dqWordT got, input dqWordT exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkCount(input string name, input mismatchCountT got,
		input mismatchCountT exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	// Inactive pins and status after reset
	task automatic checkIdle();
		checkFlag("ramOut.cs", ramOut.cs, 1'b1);
		checkFlag("ramOut.sclk", ramOut.sclk, 1'b0);
		checkFlag("ramOut.oe", ramOut.oe, 1'b0);
		checkFlag("busy", busy, 1'b0);
		checkFlag("testDone", testDone, 1'b0);
		checkFlag("testErr", testErr, 1'b0);
		checkCount("mismatchCount", mismatchCount, '0);
	endtask

	task automatic runScenario(input int scn, input logic isRead, input logic [15:0] fault,
		input logic expErr, input mismatchCountT expCnt, input bufAddrT probeA,
		input dqWordT wordA, input bufAddrT probeB, input dqWordT wordB);
		int n;
		logic prevCs;  // cs seen at the previous sample point
		scnRst = 1'b1;
		testEn = 1'b0;
		repeat (4) tick();
		scnRst = 1'b0;
		tick();
		checkIdle();
		faultEn   = (fault < 16'h0400);  // 400 and above means no fault
		faultAddr = bufAddrT'(fault);
		rwSel     = isRead;
		testEn    = 1'b1;
		prevCs    = ramOut.cs;
		n = 0;
		while (testDone !== 1'b1 && n < DONE_LIMIT)
		begin
			tick();
			checkFlag("busy", busy, ~prevCs);  // Follows cs low one cycle late
			prevCs = ramOut.cs;
			n++;
		end
		if (testDone !== 1'b1)
			abortRun($sformatf("Scenario %0d timed out waiting for testDone", scn));
		n = 0;
		while (ramOut.cs !== 1'b1 && n < CS_LIMIT)
		begin
			tick();
			n++;
		end
		if (ramOut.cs !== 1'b1)
			abortRun($sformatf("Scenario %0d left cs low after done", scn));
		// Enable still high, no second transaction may start
		repeat (8)
		begin
			tick();
			checkFlag("testDone", testDone, 1'b1);
			checkFlag("ramOut.cs", ramOut.cs, 1'b1);
		end
		checkFlag("testErr", testErr, expErr);
		checkCount("mismatchCount", mismatchCount, expCnt);
		checkWord("firstCmd", firstCmd, isRead ? RD_CMD1 : WR_CMD1);
		checkWord("secondCmd", secondCmd, isRead ? RD_CMD2 : WR_CMD2);
		testEn = 1'b0;
		memRa  = probeA;
		tick();
		checkWord("memRd", memRd, wordA);  // Registered read, one cycle
		memRa = probeB;
		tick();
		checkWord("memRd", memRd, wordB);
	endtask

	initial
	begin : mainFlow
		int fd;
		int n;
		int scnCount;
		logic [8*160-1:0] lineBuf;
		logic [15:0] field [8];  // op, fault, err, count, probeA, wordA, probeB, wordB
		scnRst    = 1'b0;
		testEn    = 1'b0;
		rwSel     = 1'b0;
		memRa     = '0;
		faultEn   = 1'b0;
		faultAddr = '0;
		scnCount  = 0;
		n = 0;
		while (porRst !== 1'b0 && n < 16)
		begin
			tick();
			n++;
		end
		if (porRst !== 1'b0)
			abortRun("Power on reset never released");
		fd = $fopen("dv/ramTestTrace.txt", "r");
		if (fd == 0)
			abortRun("Cannot open dv/ramTestTrace.txt");
		while (!$feof(fd))
		begin
			lineBuf = '0;
			n = $fgets(lineBuf, fd);
			// Comment and blank lines give fewer fields
			n = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h",
				field[0], field[1], field[2], field[3],
				field[4], field[5], field[6], field[7]);
			if (n == 8)
			begin
				runScenario(scnCount, field[0][0], field[1], field[2][0],
					mismatchCountT'(field[3]), bufAddrT'(field[4]), field[5],
					bufAddrT'(field[6]), field[7]);
				scnCount++;
			end
		end
		$fclose(fd);
		if (scnCount == 0)
			abortRun("No scenario found in the trace file");
		else
		begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// ==== dv/quadRamModel.sv ====
`timescale 1ns/1ns

module quadRamModel
(
	input  logic                iCLK,
	input  ramTestPkg::ramBusT  ramBus,     // Pins from the DUT
	input  logic                faultEn,
	input  ramTestPkg::bufAddrT faultAddr,  // Word returned inverted
	output ramTestPkg::dqWordT  ramIn,
	output ramTestPkg::dqWordT  firstCmd,   // dq at the first serial clock rise
	output ramTestPkg::dqWordT  secondCmd
);
	import ramTestPkg::*;

	localparam int WR_FIRST = 2 + ADDR_BEATS;        // First write data beat
	localparam int RD_FIRST = WR_FIRST + WAIT_BEATS;  // Reads add the latency beats

	dqWordT mem [DATA_BEATS];
	int     beat;    // Serial clock rises since cs fell
	logic   isRead;  // Decoded from the first command word

	// Stored word, inverted at the fault location
	function automatic dqWordT readWord(input bufAddrT a);
		return (faultEn && a == faultAddr) ? ~mem[a] : mem[a];
	endfunction

	initial
	begin
		foreach (mem[i])
			mem[i] <= '0;  // Unwritten RAM reads as zero
		beat      <= 0;
		isRead    <= 1'b0;
		ramIn     <= '0;
		firstCmd  <= '0;
		secondCmd <= '0;
	end

	// Values seen here are those of the cycle just ending
	always @(posedge iCLK)
	begin
		if (ramBus.cs)
		begin
			beat  <= 0;
			ramIn <= '0;
		end
		else if (!ramBus.sclk)
		begin
			// Serial clock rises now, dq is stable
			if (beat == 0)
			begin
				firstCmd <= ramBus.dq;
				isRead   <= (ramBus.dq == RD_CMD1);
			end
			if (beat == 1)
				secondCmd <= ramBus.dq;
			if (!isRead && ramBus.oe && beat >= WR_FIRST && beat < WR_FIRST + DATA_BEATS)
				mem[bufAddrT'(beat - WR_FIRST)] <= ramBus.dq;
			beat <= beat + 1;
		end
		else if (isRead && beat >= RD_FIRST && beat < RD_FIRST + DATA_BEATS)
			ramIn <= readWord(bufAddrT'(beat - RD_FIRST));  // Valid for the next low phase
		else
			ramIn <= '0;
	end

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/1ns

module tbClock
(
	output logic iCLK,
	output logic porRst  // Power on reset, active high
);
	initial
	begin
		iCLK   = 1'b0;
		porRst = 1'b1;
		repeat (4) @(posedge iCLK);  // Four rising edges in reset
		#2;
		porRst = 1'b0;  // Released with the other inputs, just after the edge
	end

	always #10 iCLK = ~iCLK;  // 20 ns period

endmodule

// ==== src/ramTestTop.sv ====
`timescale 1ns/1ns

module ramTestTop
(
	input  logic                      iCLK,
	input  logic                      iRST,
	// Host control and status
	input  logic                      testEn,
	input  logic                      rwSel,         // 0 write, 1 read
	input  ramTestPkg::bufAddrT       memRa,
	output ramTestPkg::dqWordT        memRd,
	output logic                      busy,
	output logic                      testDone,
	output logic                      testErr,
	output ramTestPkg::mismatchCountT mismatchCount,
	// RAM pins
	input  ramTestPkg::dqWordT        ramIn,
	output ramTestPkg::ramBusT        ramOut
);
	import ramTestPkg::*;

	captureT capture;  // Fans out to buffer and checker

	// Bus master, only one on the pins
	quadRamSequencer u_seq
	(
		.iCLK     (iCLK),
		.iRST     (iRST),
		.testEn   (testEn),
		.rwSel    (rwSel),
		.ramIn    (ramIn),
		.ramOut   (ramOut),
		.capture  (capture),
		.busy     (busy),
		.testDone (testDone)
	);

	// Host readable copy of the read data
	captureBuffer u_buf
	(
		.iCLK    (iCLK),
		.capture (capture),
		.memRa   (memRa),
		.memRd   (memRd)
	);

	readbackChecker u_chk
	(
		.iCLK          (iCLK),
		.iRST          (iRST),
		.capture       (capture),
		.testErr       (testErr),
		.mismatchCount (mismatchCount)
	);

endmodule

// ==== src/readbackChecker.sv ====
`timescale 1ns/1ns

module readbackChecker
(
	input  logic                      iCLK,
	input  logic                      iRST,
	input  ramTestPkg::captureT       capture,       // Same beats the buffer stores
	output logic                      testErr,       // Sticky
	output ramTestPkg::mismatchCountT mismatchCount  // Saturating
);
	import ramTestPkg::*;

	logic    capValid;  // Staged beat present
	bufAddrT capIdx;
	dqWordT  capWord;
	logic    wordBad;
	logic    countFull;

	// Stage one, register the beat
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			capValid <= 1'b0;
		end
		else
		begin
			capValid <= capture.we;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (capture.we)
		begin
			capIdx  <= capture.idx;
			capWord <= capture.data;
		end
	end

	// Written pattern is the beat index zero extended
	assign wordBad   = capValid & (capWord != dqWordT'(capIdx));
	assign countFull = &mismatchCount;  // Saturates at all ones

	// Stage two, flag and count
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			testErr       <= 1'b0;
			mismatchCount <= '0;
		end
		else if (wordBad)
		begin
			testErr <= 1'b1;
			if (!countFull)
			begin
				mismatchCount <= mismatchCount + 1'b1;
			end
		end
	end

	// At most one bad word per buffer slot
	aCountBound: assert property (@(posedge iCLK) disable iff (iRST)
		mismatchCount <= mismatchCountT'(DATA_BEATS));

endmodule

// ==== src/captureBuffer.sv ====
`timescale 1ns/1ns

module captureBuffer
(
	input  logic                iCLK,
	input  ramTestPkg::captureT capture,  // Strobed read beats from the sequencer
	input  ramTestPkg::bufAddrT memRa,    // Host read address
	output ramTestPkg::dqWordT  memRd     // Host read data, one cycle after memRa
);
	import ramTestPkg::*;

	// One slot per data beat
	dqWordT mem [DATA_BEATS];

	// Write side, indexed by beat number
	always_ff @(posedge iCLK)
	begin
		if (capture.we)
		begin
			mem[capture.idx] <= capture.data;
		end
	end

	// Host side
	// Registered read so the array maps onto block RAM
	always_ff @(posedge iCLK)
	begin
		memRd <= mem[memRa];
	end

endmodule

// ==== src/quadRamSequencer.sv ====
`timescale 1ns/1ns

module quadRamSequencer
(
	input  logic               iCLK,
	input  logic               iRST,
	input  logic               testEn,    // Level, held for the whole transaction
	input  logic               rwSel,     // 0 write, 1 read
	input  ramTestPkg::dqWordT ramIn,     // Data returned by the RAM
	output ramTestPkg::ramBusT ramOut,
	output ramTestPkg::captureT capture,  // Read beats toward buffer and checker
	output logic               busy,
	output logic               testDone
);
	import ramTestPkg::*;

	seqStateT  state;
	seqStateT  nextState;
	beatCountT beatCnt;     // Beat within the current phase
	beatCountT phaseLast;   // Index of the final beat of the phase
	dqWordT    dqReg;
	dqWordT    dqNext;
	logic      csReg;
	logic      sclkReg;
	logic      oeReg;
	logic      oeNext;
	logic      run;
	logic      beatTick;
	logic      phaseEnd;
	logic      dqLoad;

	// Transaction runs until done, then waits for reset
	assign run      = testEn & ~testDone;
	// Low serial clock phase of a live beat
	assign beatTick = ~csReg & ~sclkReg;
	assign phaseEnd = beatTick & (beatCnt == phaseLast);
	// Preload before cs falls, then reload on every high phase
	assign dqLoad   = run & (csReg | sclkReg);

	// Phase lengths
	always_comb
	begin
		case (state)
			stCmd1,
			stCmd2:  phaseLast = beatCountT'(CMD_BEATS - 1);
			stAdrs:  phaseLast = beatCountT'(ADDR_BEATS - 1);
			stWait:  phaseLast = beatCountT'(WAIT_BEATS - 1);
			default: phaseLast = beatCountT'(DATA_BEATS - 1);
		endcase
	end

	// Phase order, wait only on reads
	always_comb
	begin
		case (state)
			stCmd1:  nextState = stCmd2;
			stCmd2:  nextState = stAdrs;
			stAdrs:  nextState = rwSel ? stWait : stData;
			stWait:  nextState = stData;
			default: nextState = stCmd1;  // Data ends the transaction
		endcase
	end

	// Word for the beat that state and count point at
	always_comb
	begin
		case (state)
			stCmd1:
			begin
				dqNext = rwSel ? RD_CMD1 : WR_CMD1;
				oeNext = 1'b1;
			end
			stCmd2:
			begin
				dqNext = rwSel ? RD_CMD2 : WR_CMD2;
				oeNext = 1'b1;
			end
			stAdrs:
			begin
				dqNext = '0;    // Start address fixed at zero
				oeNext = 1'b1;
			end
			stWait:
			begin
				dqNext = '0;
				oeNext = 1'b0;  // Bus turned around for the RAM
			end
			default:
			begin
				// Incrementing pattern on writes, pads released on reads
				dqNext = rwSel ? '0 : dqWordT'(beatCnt);
				oeNext = ~rwSel;
			end
		endcase
	end

	// Phase and beat tracking, steps on the low phase
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state   <= stCmd1;
			beatCnt <= '0;
		end
		else if (phaseEnd)
		begin
			state   <= nextState;
			beatCnt <= '0;
		end
		else if (beatTick)
		begin
			beatCnt <= beatCnt + 1'b1;
		end
	end

	// Pin and status registers
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			csReg    <= 1'b1;
			sclkReg  <= 1'b0;
			dqReg    <= '0;
			oeReg    <= 1'b0;
			busy     <= 1'b0;
			testDone <= 1'b0;
		end
		else
		begin
			csReg   <= ~run;
			sclkReg <= csReg ? 1'b0 : ~sclkReg;  // Parks low while deselected
			if (dqLoad)
			begin
				dqReg <= dqNext;  // Lands as sclk falls
				oeReg <= oeNext;
			end
			else if (!run)
			begin
				oeReg <= 1'b0;
			end
			busy <= ~csReg;  // One cycle behind cs
			if (phaseEnd && state == stData)
			begin
				testDone <= 1'b1;  // Sticky until reset
			end
		end
	end

	assign ramOut.dq   = dqReg;
	assign ramOut.cs   = csReg;
	assign ramOut.sclk = sclkReg;
	assign ramOut.oe   = oeReg;

	// Read data sampled in the low phase of each data beat
	assign capture.we   = beatTick & rwSel & (state == stData);
	assign capture.idx  = bufAddrT'(beatCnt);
	assign capture.data = ramIn;

	aStateLegal: assert property (@(posedge iCLK) disable iff (iRST)
		state inside {stCmd1, stCmd2, stAdrs, stWait, stData});

	// Pads released for every captured read beat
	aCaptureRead: assert property (@(posedge iCLK) disable iff (iRST)
		capture.we |-> !oeReg);

endmodule

// ==== src/ramTestPkg.sv ====
package ramTestPkg;

	// Word widths with a meaning of their own
	typedef logic [15:0] dqWordT;         // One beat on the RAM data pins
	typedef logic [9:0]  bufAddrT;        // Capture buffer slot, also the data beat index
	typedef logic [10:0] beatCountT;      // Beat count inside one phase
	typedef logic [10:0] mismatchCountT;  // Bad words seen, up to a full buffer

	// Transaction phases in bus order
	typedef enum logic [2:0]
	{
		stCmd1,  // First command beat
		stCmd2,  // Second command beat
		stAdrs,  // Address beats, always zero here
		stWait,  // Latency beats, read only
		stData   // Payload beats
	} seqStateT;

	// Pin bundle toward the RAM
	typedef struct packed
	{
		dqWordT dq;    // Driven data, valid while oe high
		logic   cs;    // Chip select, active low
		logic   sclk;  // Serial clock, half rate of iCLK
		logic   oe;    // Output enable of the dq pads
	} ramBusT;

	// One captured read beat
	typedef struct packed
	{
		logic    we;    // Single cycle write strobe
		bufAddrT idx;   // Beat number from zero
		dqWordT  data;  // Word seen on ramIn
	} captureT;

	// Beats per phase
	localparam int DATA_BEATS = 1024;
	localparam int ADDR_BEATS = 6;
	localparam int WAIT_BEATS = 6;
	localparam int CMD_BEATS  = 1;   // Same for both command states

	// Quad mode command pairs
	localparam dqWordT WR_CMD1 = 16'h3333;
	localparam dqWordT WR_CMD2 = 16'h8888;
	localparam dqWordT RD_CMD1 = 16'hEEEE;
	localparam dqWordT RD_CMD2 = 16'hBBBB;

endpackage
